// ==== mc_wh_flit_deserializer.sv ====
// Inbound serial-in parallel-out stage.
// Collects one packet of flits, checks its length field and hands the
// payload to the manycore side, or drops it with a one-cycle error pulse.
`default_nettype none

`include "mc_wh_macros.svh"

module mc_wh_flit_deserializer
  (input  wire logic                            clk_i
  ,input  wire logic                            rst_i

  // Flits from the inbound FIFO
  ,input  wire logic                            in_v_i
  ,input  wire logic [`MC_WH_FLIT_WIDTH-1:0]    in_flit_i
  ,output logic                                 in_ready_o

  // Manycore side
  ,output logic                                 mc_v_o
  ,output logic [`MC_WH_PAYLOAD_WIDTH-1:0]      mc_data_o
  ,input  wire logic                            mc_ready_i

  // Dropped packet with a bad length field
  ,output logic                                 len_err_o
  );

  import mc_wh_pkg::*;

  localparam int cnt_width_lp = $clog2(`MC_WH_RATIO);
  localparam logic [cnt_width_lp-1:0]     last_lp = cnt_width_lp'(`MC_WH_RATIO - 1);
  localparam logic [`MC_WH_LEN_WIDTH-1:0] len_lp  = `MC_WH_LEN_WIDTH'(`MC_WH_RATIO - 1);

  logic                    full_r;
  logic [cnt_width_lp-1:0] cnt_r;
  wh_packet_u              pkt_r;
  logic                    take_w;
  logic                    last_w;
  logic                    len_ok_w;

  // Collecting whenever no finished packet is held
  assign in_ready_o = ~full_r;
  assign take_w     = in_v_i & ~full_r;
  assign last_w     = (cnt_r == last_lp);

  // Coordinates and reserved bits are ignored; routing is already done
  assign len_ok_w  = (pkt_r.hdr.len == len_lp);
  assign mc_v_o    = full_r & len_ok_w;
  assign len_err_o = full_r & ~len_ok_w;
  assign mc_data_o = pkt_r.hdr.payload;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      full_r <= 1'b0;
      cnt_r  <= '0;
    end
    else if (!full_r)
    begin
      if (take_w)
      begin
        full_r <= last_w;
        cnt_r  <= last_w ? '0 : cnt_r + 1'b1;
      end
    end
    // A bad packet is held for one cycle only
    else if (mc_ready_i || !len_ok_w)
      full_r <= 1'b0;
  end

  // Head flit ends up in the most significant slot
  always_ff @(posedge clk_i)
  begin
    if (take_w)
      pkt_r.flits <= {pkt_r.flits[`MC_WH_RATIO-2:0], in_flit_i};
  end

  a_err_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    len_err_o |=> !len_err_o);

endmodule

`default_nettype wire

// ==== mc_wh_flit_fifo.sv ====
// Single-clock flit FIFO with valid/ready on both sides.
// Used once per direction; the depth is 2**lg_depth_p entries.
`default_nettype none

`include "mc_wh_macros.svh"

module mc_wh_flit_fifo
 #(parameter int lg_depth_p = `MC_WH_FIFO_LG_DEPTH)
  (input  wire logic                         clk_i
  ,input  wire logic                         rst_i

  // Write side
  ,input  wire logic                         v_i
  ,input  wire logic [`MC_WH_FLIT_WIDTH-1:0] data_i
  ,output logic                              ready_o

  // Read side
  ,output logic                              v_o
  ,output logic [`MC_WH_FLIT_WIDTH-1:0]      data_o
  ,input  wire logic                         ready_i
  );

  localparam int depth_lp = 1 << lg_depth_p;

  logic [`MC_WH_FLIT_WIDTH-1:0] mem_r [depth_lp];
  logic [lg_depth_p-1:0]        wr_ptr_r;
  logic [lg_depth_p-1:0]        rd_ptr_r;
  logic [lg_depth_p:0]          count_r;
  logic                         full_w;
  logic                         push_w;
  logic                         pop_w;

  // Top bit of the count is only set at exactly depth_lp entries
  assign full_w = count_r[lg_depth_p];

  // A full FIFO still takes a flit when one leaves in the same cycle
  assign ready_o = ~full_w | ready_i;
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  assign push_w = v_i & ready_o;
  assign pop_w  = v_o & ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      // Pointers wrap on their own
      if (push_w)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop_w)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      if (push_w && !pop_w)
        count_r <= count_r + 1'b1;
      else if (pop_w && !push_w)
        count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_w)
      mem_r[wr_ptr_r] <= data_i;
  end

  // No write lands on a full FIFO, so the count stays within the depth
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    count_r <= depth_lp);

endmodule

`default_nettype wire

// ==== mc_wh_flit_serializer.sv ====
// Outbound parallel-in serial-out stage.
// Loads one wormhole packet when idle and sends it head flit first.
`default_nettype none

`include "mc_wh_macros.svh"

module mc_wh_flit_serializer
  (input  wire logic                         clk_i
  ,input  wire logic                         rst_i

  // Packet from the framer
  ,input  wire logic                         fr_v_i
  ,input  wire mc_wh_pkg::wh_packet_u        fr_pkt_i
  ,output logic                              fr_ready_o

  // Flits toward the outbound FIFO
  ,output logic                              ser_v_o
  ,output logic [`MC_WH_FLIT_WIDTH-1:0]      ser_flit_o
  ,input  wire logic                         ser_ready_i
  );

  import mc_wh_pkg::*;

  localparam int cnt_width_lp = $clog2(`MC_WH_RATIO);
  localparam logic [cnt_width_lp-1:0] head_lp = cnt_width_lp'(`MC_WH_RATIO - 1);

  logic                    busy_r;
  logic [cnt_width_lp-1:0] cnt_r;
  wh_packet_u              pkt_r;
  logic                    load_w;
  logic                    send_w;

  // Takes a new packet only between packets
  assign fr_ready_o = ~busy_r;
  assign load_w     = fr_v_i & ~busy_r;
  assign send_w     = busy_r & ser_ready_i;

  assign ser_v_o    = busy_r;
  // cnt_r counts down from the head flit
  assign ser_flit_o = pkt_r.flits[cnt_r];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_r <= 1'b0;
      cnt_r  <= head_lp;
    end
    else if (load_w)
    begin
      busy_r <= 1'b1;
      cnt_r  <= head_lp;
    end
    else if (send_w)
    begin
      // Tail flit accepted
      if (cnt_r == '0)
        busy_r <= 1'b0;
      else
        cnt_r <= cnt_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load_w)
      pkt_r <= fr_pkt_i;
  end

  // A stalled flit must not change under the FIFO
  a_flit_held: assert property (@(posedge clk_i) disable iff (rst_i)
    ser_v_o && !ser_ready_i |=> ser_v_o && $stable(ser_flit_o));

endmodule

`default_nettype wire

// ==== mc_wh_link_adapter.sv ====
// Manycore to wormhole link adapter, single clock domain.
// Outbound: framer, serializer, FIFO. Inbound: FIFO, deserializer.
`default_nettype none

`include "mc_wh_macros.svh"

module mc_wh_link_adapter
  (input  wire logic                            clk_i
  ,input  wire logic                            rst_i

  // Destination of outbound packets, set before reset is released
  ,input  wire logic [`MC_WH_X_WIDTH-1:0]       dest_x_i
  ,input  wire logic [`MC_WH_Y_WIDTH-1:0]       dest_y_i

  // Manycore link
  ,input  wire logic                            mc_v_i
  ,input  wire logic [`MC_WH_PAYLOAD_WIDTH-1:0] mc_data_i
  ,output logic                                 mc_ready_o
  ,output logic                                 mc_v_o
  ,output logic [`MC_WH_PAYLOAD_WIDTH-1:0]      mc_data_o
  ,input  wire logic                            mc_ready_i
  ,output logic                                 len_err_o

  // Wormhole link
  ,input  wire logic                            wh_v_i
  ,input  wire logic [`MC_WH_FLIT_WIDTH-1:0]    wh_data_i
  ,output logic                                 wh_ready_o
  ,output logic                                 wh_v_o
  ,output logic [`MC_WH_FLIT_WIDTH-1:0]         wh_data_o
  ,input  wire logic                            wh_ready_i
  );

  import mc_wh_pkg::*;

  // Outbound path
  logic                         fr_v;
  wh_packet_u                   fr_pkt;
  logic                         fr_ready;
  logic                         ser_v;
  logic [`MC_WH_FLIT_WIDTH-1:0] ser_flit;
  logic                         ser_ready;

  // Inbound path
  logic                         in_v;
  logic [`MC_WH_FLIT_WIDTH-1:0] in_flit;
  logic                         in_ready;

  mc_wh_packet_framer framer
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.dest_x_i(dest_x_i)
    ,.dest_y_i(dest_y_i)
    ,.mc_v_i(mc_v_i)
    ,.mc_data_i(mc_data_i)
    ,.mc_ready_o(mc_ready_o)
    ,.fr_v_o(fr_v)
    ,.fr_pkt_o(fr_pkt)
    ,.fr_ready_i(fr_ready));

  mc_wh_flit_serializer serializer
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.fr_v_i(fr_v)
    ,.fr_pkt_i(fr_pkt)
    ,.fr_ready_o(fr_ready)
    ,.ser_v_o(ser_v)
    ,.ser_flit_o(ser_flit)
    ,.ser_ready_i(ser_ready));

  mc_wh_flit_fifo out_fifo
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.v_i(ser_v)
    ,.data_i(ser_flit)
    ,.ready_o(ser_ready)
    ,.v_o(wh_v_o)
    ,.data_o(wh_data_o)
    ,.ready_i(wh_ready_i));

  mc_wh_flit_fifo in_fifo
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.v_i(wh_v_i)
    ,.data_i(wh_data_i)
    ,.ready_o(wh_ready_o)
    ,.v_o(in_v)
    ,.data_o(in_flit)
    ,.ready_i(in_ready));

  mc_wh_flit_deserializer deserializer
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.in_v_i(in_v)
    ,.in_flit_i(in_flit)
    ,.in_ready_o(in_ready)
    ,.mc_v_o(mc_v_o)
    ,.mc_data_o(mc_data_o)
    ,.mc_ready_i(mc_ready_i)
    ,.len_err_o(len_err_o));

endmodule

`default_nettype wire

// ==== mc_wh_macros.svh ====
// Widths and depths shared by the manycore to wormhole link adapter.
// Include this in every file that sizes a port, a register or a FIFO from these values.
`ifndef MC_WH_MACROS_SVH
`define MC_WH_MACROS_SVH

// Wormhole flit and the number of flits per packet
`define MC_WH_FLIT_WIDTH 16
`define MC_WH_RATIO 4
`define MC_WH_PKT_WIDTH (`MC_WH_FLIT_WIDTH * `MC_WH_RATIO)

// Header fields, msb to lsb after the payload: len, y, x, reserved
`define MC_WH_X_WIDTH 4
`define MC_WH_Y_WIDTH 3
`define MC_WH_LEN_WIDTH 3
`define MC_WH_RSV_WIDTH 2

// Whatever the header leaves over carries the manycore packet
`define MC_WH_PAYLOAD_WIDTH (`MC_WH_PKT_WIDTH - `MC_WH_LEN_WIDTH - `MC_WH_Y_WIDTH \
  - `MC_WH_X_WIDTH - `MC_WH_RSV_WIDTH)

// 8 entries per flit FIFO
`define MC_WH_FIFO_LG_DEPTH 3

`endif

// ==== mc_wh_packet_framer.sv ====
// Outbound stage that wraps a manycore payload in a wormhole header.
// One-entry register slice with valid/ready on both sides; full throughput.
`default_nettype none

`include "mc_wh_macros.svh"

module mc_wh_packet_framer
  (input  wire logic                            clk_i
  ,input  wire logic                            rst_i

  // Quasi-static destination, sampled per accepted packet
  ,input  wire logic [`MC_WH_X_WIDTH-1:0]       dest_x_i
  ,input  wire logic [`MC_WH_Y_WIDTH-1:0]       dest_y_i

  // Manycore side
  ,input  wire logic                            mc_v_i
  ,input  wire logic [`MC_WH_PAYLOAD_WIDTH-1:0] mc_data_i
  ,output logic                                 mc_ready_o

  // Toward the serializer
  ,output logic                                 fr_v_o
  ,output mc_wh_pkg::wh_packet_u                fr_pkt_o
  ,input  wire logic                            fr_ready_i
  );

  import mc_wh_pkg::*;

  // Flits in a packet, minus one, as the length field expects
  localparam logic [`MC_WH_LEN_WIDTH-1:0] len_lp = `MC_WH_LEN_WIDTH'(`MC_WH_RATIO - 1);

  logic accept_w;

  // Room when empty or when the held packet leaves this cycle
  assign mc_ready_o = ~fr_v_o | fr_ready_i;
  assign accept_w   = mc_v_i & mc_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      fr_v_o <= 1'b0;
    else if (mc_ready_o)
      fr_v_o <= mc_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_w)
    begin
      fr_pkt_o.hdr.payload  <= mc_data_i;
      fr_pkt_o.hdr.len      <= len_lp;
      fr_pkt_o.hdr.y_cord   <= dest_y_i;
      fr_pkt_o.hdr.x_cord   <= dest_x_i;
      fr_pkt_o.hdr.reserved <= '0;
    end
  end

  // A stalled packet must not change under the serializer
  a_pkt_held: assert property (@(posedge clk_i) disable iff (rst_i)
    fr_v_o && !fr_ready_i |=> fr_v_o && $stable(fr_pkt_o));

endmodule

`default_nettype wire

// ==== mc_wh_pkg.sv ====
// Types shared by the link adapter stages.
// Import inside a module body, or use scoped names in port lists.
`default_nettype none

`include "mc_wh_macros.svh"

package mc_wh_pkg;

  // One wormhole packet word, seen either as header fields or as flits.
  // The framer and the deserializer's checker use hdr; the serializer and the
  // deserializer's shifter use flits. flits[RATIO-1] is the head flit
  typedef union packed
  {
    struct packed
    {
      logic [`MC_WH_PAYLOAD_WIDTH-1:0] payload;
      logic [`MC_WH_LEN_WIDTH-1:0]     len;
      logic [`MC_WH_Y_WIDTH-1:0]       y_cord;
      logic [`MC_WH_X_WIDTH-1:0]       x_cord;
      logic [`MC_WH_RSV_WIDTH-1:0]     reserved;
    } hdr;
    logic [`MC_WH_RATIO-1:0][`MC_WH_FLIT_WIDTH-1:0] flits;
  } wh_packet_u;

endpackage

`default_nettype wire

// ==== mc_wh_testdata.txt ====
# T kind dest_x dest_y stall_pct packets (kind, stall_pct, packets decimal; dests hex)
# O payload | I flit3 flit2 flit1 flit0 len_err expected_payload (hex, flit3 sent first)
T 1 5 2 0 2
O 0000000000001
O 123456789ABCD
T 1 A 6 0 2
O FFFFFFFFFFFFF
O A5A5A5A5A5A5A
T 2 5 2 0 2
I 0123 4567 89AB C694 0 0123456789ABC
I FEDC BA98 7654 3600 0 FEDCBA9876543
T 3 5 2 0 4
I 1111 1111 1111 1494 1 0
I 2222 2222 2222 2694 0 2222222222222
I 3333 3333 3333 3E94 1 0
I 4444 4444 4444 464C 0 4444444444444
T 4 3 1 60 5
O 1000000000000
O 2000000000001
O 3000000000002
O 4000000000003
O 5000000000004
T 5 3 1 85 6
I ABCD EF01 2345 6600 0 ABCDEF0123456
I 0F1E 2D3C 4B5A 6694 0 0F1E2D3C4B5A6
I 7968 5746 3524 164C 0 7968574635241
I 8000 0000 0000 17FF 0 8000000000001
I 0000 0000 0000 0600 0 0000000000000
I FFFF FFFF FFFF F694 0 FFFFFFFFFFFFF
T 6 C 5 40 6
O 0246813579BDF
I 1357 9BDF 0246 8694 0 13579BDF02468
O 1111222233334
I 2468 ACE0 1357 9094 1 0
O 7777777777777
I 9876 5432 10FE D600 0 9876543210FED

// ==== tb_mc_wh_link_adapter.sv ====
// Self-checking testbench for the manycore to wormhole link adapter.
// Tests come from mc_wh_testdata.txt. Outbound flits are predicted through
// the packet union; inbound payloads and length errors come from the file.
`default_nettype none

`include "mc_wh_macros.svh"

module tb_mc_wh_link_adapter;

  import mc_wh_pkg::*;

  logic                            clk_i = 1'b0;
  logic                            rst_i = 1'b1;
  logic [`MC_WH_X_WIDTH-1:0]       dest_x_i = '0;
  logic [`MC_WH_Y_WIDTH-1:0]       dest_y_i = '0;
  logic                            mc_v_i = 1'b0;
  logic [`MC_WH_PAYLOAD_WIDTH-1:0] mc_data_i = '0;
  logic                            mc_ready_i = 1'b1;
  logic                            wh_v_i = 1'b0;
  logic [`MC_WH_FLIT_WIDTH-1:0]    wh_data_i = '0;
  logic                            wh_ready_i = 1'b1;
  logic                            mc_ready_o;
  logic                            mc_v_o;
  logic [`MC_WH_PAYLOAD_WIDTH-1:0] mc_data_o;
  logic                            len_err_o;
  logic                            wh_ready_o;
  logic                            wh_v_o;
  logic [`MC_WH_FLIT_WIDTH-1:0]    wh_data_o;

  // Test records, and the packets they own in file order
  int                              tk_kind[$], tk_stall[$], tk_count[$];
  logic [`MC_WH_X_WIDTH-1:0]       tk_dx[$];
  logic [`MC_WH_Y_WIDTH-1:0]       tk_dy[$];
  bit                              pk_in[$];
  logic [`MC_WH_PAYLOAD_WIDTH-1:0] pk_pay[$];
  logic [`MC_WH_PKT_WIDTH-1:0]     pk_word[$];
  logic                            pk_err[$];

  // Driver input, monitor output and expected results
  logic [`MC_WH_PAYLOAD_WIDTH-1:0] drv_pay_q[$], in_pay_q[$], exp_pay_q[$];
  logic [`MC_WH_PKT_WIDTH-1:0]     drv_word_q[$];
  logic [`MC_WH_FLIT_WIDTH-1:0]    out_flit_q[$], exp_flit_q[$];
  logic                            in_err_q[$], exp_err_q[$];

  int stall_pct = 0;
  int errors = 0;
  int n_pass = 0;
  int n_fail = 0;
  bit saw_mc_stall;
  bit saw_wh_stall;

  mc_wh_link_adapter i_mc_wh_link_adapter
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.dest_x_i(dest_x_i)
    ,.dest_y_i(dest_y_i)
    ,.mc_v_i(mc_v_i)
    ,.mc_data_i(mc_data_i)
    ,.mc_ready_o(mc_ready_o)
    ,.mc_v_o(mc_v_o)
    ,.mc_data_o(mc_data_o)
    ,.mc_ready_i(mc_ready_i)
    ,.len_err_o(len_err_o)
    ,.wh_v_i(wh_v_i)
    ,.wh_data_i(wh_data_i)
    ,.wh_ready_o(wh_ready_o)
    ,.wh_v_o(wh_v_o)
    ,.wh_data_o(wh_data_o)
    ,.wh_ready_i(wh_ready_i));

  always #2 clk_i = ~clk_i;

  // Random stalls on both ready inputs
  always @(posedge clk_i)
  begin
    wh_ready_i <= (($urandom % 100) >= stall_pct);
    mc_ready_i <= (($urandom % 100) >= stall_pct);
  end

  // Each inbound packet ends either as a payload or as one error pulse
  always @(posedge clk_i)
  begin
    if (!rst_i)
    begin
      if (wh_v_o && wh_ready_i)
        out_flit_q.push_back(wh_data_o);
      if (mc_v_o && mc_ready_i)
      begin
        in_err_q.push_back(1'b0);
        in_pay_q.push_back(mc_data_o);
      end
      if (len_err_o)
      begin
        in_err_q.push_back(1'b1);
        in_pay_q.push_back('0);
      end
    end
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_flit(input logic [`MC_WH_FLIT_WIDTH-1:0] exp,
                            input logic [`MC_WH_FLIT_WIDTH-1:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH at %0t: wh_data_o expected %h got %h", $time, exp, act);
      errors++;
    end
  endtask

  task automatic check_payload(input logic [`MC_WH_PAYLOAD_WIDTH-1:0] exp,
                               input logic [`MC_WH_PAYLOAD_WIDTH-1:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH at %0t: mc_data_o expected %h got %h", $time, exp, act);
      errors++;
    end
  endtask

  task automatic check_err(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("MISMATCH at %0t: len_err_o expected %b got %b", $time, exp, act);
      errors++;
    end
  endtask

  task automatic load_tests();
    int                              fd;
    int                              code;
    int                              kind, dx, dy, stall, count, err;
    logic [7:0]                      tag;
    logic [8*160-1:0]                rest;
    logic [`MC_WH_FLIT_WIDTH-1:0]    f3, f2, f1, f0;
    logic [`MC_WH_PAYLOAD_WIDTH-1:0] pay;
    fd = $fopen("mc_wh_testdata.txt", "r");
    if (fd == 0)
      report_error("cannot open mc_wh_testdata.txt");
    else
    begin
      while ($fscanf(fd, " %c", tag) == 1)
      begin
        if (tag == "#")
          code = $fgets(rest, fd);
        else if (tag == "T")
        begin
          code = $fscanf(fd, "%d %h %h %d %d", kind, dx, dy, stall, count);
          tk_kind.push_back(kind);
          tk_dx.push_back(`MC_WH_X_WIDTH'(dx));
          tk_dy.push_back(`MC_WH_Y_WIDTH'(dy));
          tk_stall.push_back(stall);
          tk_count.push_back(count);
        end
        else if (tag == "O" || tag == "I")
        begin
          f3 = '0;
          f2 = '0;
          f1 = '0;
          f0 = '0;
          err = 0;
          if (tag == "O")
            code = $fscanf(fd, "%h", pay);
          else
            code = $fscanf(fd, "%h %h %h %h %d %h", f3, f2, f1, f0, err, pay);
          pk_in.push_back(tag == "I");
          pk_pay.push_back(pay);
          pk_word.push_back({f3, f2, f1, f0});
          pk_err.push_back(err != 0);
        end
        else
          report_error("unknown record type in mc_wh_testdata.txt");
      end
      $fclose(fd);
    end
  endtask

  task automatic send_payloads();
    while (drv_pay_q.size() > 0)
    begin
      mc_v_i    <= 1'b1;
      mc_data_i <= drv_pay_q.pop_front();
      @(posedge clk_i);
      while (!mc_ready_o)
      begin
        saw_mc_stall = 1'b1;
        @(posedge clk_i);
      end
    end
    mc_v_i <= 1'b0;
  endtask

  task automatic send_flits();
    wh_packet_u pkt;
    int         i;
    while (drv_word_q.size() > 0)
    begin
      pkt = drv_word_q.pop_front();
      // Head flit goes first
      for (i = `MC_WH_RATIO - 1; i >= 0; i--)
      begin
        wh_v_i    <= 1'b1;
        wh_data_i <= pkt.flits[i];
        @(posedge clk_i);
        while (!wh_ready_o)
        begin
          saw_wh_stall = 1'b1;
          @(posedge clk_i);
        end
      end
    end
    wh_v_i <= 1'b0;
  endtask

  task automatic run_test(input int t);
    wh_packet_u pkt;
    int         first_err;
    int         n_out;
    int         n_in;
    int         i;
    logic       exp_e;
    logic       act_e;
    first_err = errors;
    @(posedge clk_i);
    dest_x_i     <= tk_dx[t];
    dest_y_i     <= tk_dy[t];
    stall_pct    = tk_stall[t];
    saw_mc_stall = 1'b0;
    saw_wh_stall = 1'b0;
    repeat (tk_count[t])
    begin
      if (pk_in[0])
      begin
        drv_word_q.push_back(pk_word[0]);
        exp_err_q.push_back(pk_err[0]);
        exp_pay_q.push_back(pk_pay[0]);
      end
      else
      begin
        drv_pay_q.push_back(pk_pay[0]);
        // Header of three flits after the head, reserved bits clear
        pkt.hdr.payload  = pk_pay[0];
        pkt.hdr.len      = `MC_WH_LEN_WIDTH'd3;
        pkt.hdr.y_cord   = tk_dy[t];
        pkt.hdr.x_cord   = tk_dx[t];
        pkt.hdr.reserved = '0;
        for (i = `MC_WH_RATIO - 1; i >= 0; i--)
          exp_flit_q.push_back(pkt.flits[i]);
      end
      void'(pk_in.pop_front());
      void'(pk_pay.pop_front());
      void'(pk_word.pop_front());
      void'(pk_err.pop_front());
    end
    n_out = exp_flit_q.size();
    n_in  = exp_err_q.size();
    fork
      send_payloads();
      send_flits();
    join
    while (out_flit_q.size() < n_out || in_err_q.size() < n_in)
      @(posedge clk_i);
    // Let any extra flit or payload show up before counting
    stall_pct = 0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    if (out_flit_q.size() != n_out)
      report_error($sformatf("%0d flits left wh_data_o, %0d expected", out_flit_q.size(), n_out));
    if (in_err_q.size() != n_in)
      report_error($sformatf("%0d inbound results seen, %0d expected", in_err_q.size(), n_in));
    while (exp_flit_q.size() > 0 && out_flit_q.size() > 0)
      check_flit(exp_flit_q.pop_front(), out_flit_q.pop_front());
    while (exp_err_q.size() > 0 && in_err_q.size() > 0)
    begin
      exp_e = exp_err_q.pop_front();
      act_e = in_err_q.pop_front();
      check_err(exp_e, act_e);
      if (!exp_e && !act_e)
        check_payload(exp_pay_q[0], in_pay_q[0]);
      void'(exp_pay_q.pop_front());
      void'(in_pay_q.pop_front());
    end
    exp_flit_q.delete();
    out_flit_q.delete();
    exp_err_q.delete();
    exp_pay_q.delete();
    in_err_q.delete();
    in_pay_q.delete();
    if (tk_kind[t] == 4 && !saw_mc_stall)
      report_error("mc_ready_o never dropped during the outbound burst");
    if (tk_kind[t] == 5 && !saw_wh_stall)
      report_error("wh_ready_o never dropped during the inbound burst");
    if (errors == first_err)
      n_pass++;
    else
      n_fail++;
    $display("test %0d kind %0d: %0d flits out, %0d packets in, %s", t + 1, tk_kind[t],
             n_out, n_in, (errors == first_err) ? "ok" : "errors");
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", cycles);
    $display("*** FAILED ***");
    $finish;
  endtask

  initial
  begin
    void'($urandom(32'h29253a22));
    load_tests();
    fork
      watchdog(200 * tk_kind.size() + 100);
    join_none
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int t = 0; t < tk_kind.size(); t++)
      run_test(t);
    $display("%0d tests passed, %0d tests failed, %0d errors", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mc_wh_pkg.sv
mc_wh_packet_framer.sv
mc_wh_flit_serializer.sv
mc_wh_flit_fifo.sv
mc_wh_flit_deserializer.sv
mc_wh_link_adapter.sv
tb_mc_wh_link_adapter.sv
